/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // pc and memory index widths
    localparam int addr_w = 48;
    // index is pc[21:3]
    localparam int index_w = 19;
    // only the low bits reach the array, upper index bits alias
    localparam int mem_index_bits = 10;

    // one fetch word holds two instructions
    localparam int word_w = 64;
    localparam int inst_w = 32;

    // cycles from accepted request to done
    localparam int mem_latency = 2;

    // request side of the memory handshake
    typedef struct packed {
        logic               valid;
        logic [index_w-1:0] index;
    } mem_req_t;

    // done is a single pulse carrying the word
    typedef struct packed {
        logic              done;
        logic [word_w-1:0] data;
    } mem_rsp_t;

    // pc_ctrl states
    typedef enum logic [3:0] {
        boot_setting,
        wait_for_fire,
        ongoing_normal_fetch,
        normal_finish,
        wait_for_ibuffer,
        ongoing_redirect_fetch,
        redirect_finish,
        ongoing_wasted_fetch,
        wasted_fetch_finish
    } pc_state_e;

    // who holds the memory
    typedef enum logic {
        owner_fetch,
        owner_data
    } arb_owner_e;

endpackage

`default_nettype wire

/* src/pc_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module pc_ctrl (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire  [fetch_pkg::addr_w-1:0] boot_addr,
    input  wire                          redirect_valid,
    input  wire  [fetch_pkg::addr_w-1:0] redirect_target,
    output fetch_pkg::mem_req_t          req,
    input  wire                          req_ready,
    input  wire  fetch_pkg::mem_rsp_t    rsp,
    output logic [fetch_pkg::addr_w-1:0] pc,
    output logic                         word_valid,
    output logic [fetch_pkg::word_w-1:0] word_data,
    output logic                         clear_ibuffer,
    input  wire                          can_accept
);
    import fetch_pkg::*;

    pc_state_e          state_q;
    pc_state_e          state_d;
    logic               redir_pend_q;
    logic [addr_w-1:0]  redir_target_q;
    logic               redirect_any;
    logic [addr_w-1:0]  target_any;
    logic               from_redirect_q;
    logic               unaligned_q;
    logic [word_w-1:0]  word_q;
    logic               load_target;
    logic               step_pc;

    // live redirect wins over the latched one
    assign redirect_any = redirect_valid | redir_pend_q;
    assign target_any   = redirect_valid ? redirect_target : redir_target_q;

    // request is the word holding pc
    assign req.valid = (state_q == wait_for_fire);
    assign req.index = pc[index_w+2:3];

    // old instructions are flushed as soon as the redirect shows up
    assign clear_ibuffer = redirect_valid;
    assign word_data     = word_q;

    always_comb begin
        state_d     = state_q;
        load_target = 1'b0;
        step_pc     = 1'b0;
        word_valid  = 1'b0;
        case (state_q)
            boot_setting: begin
                state_d = wait_for_fire;
            end
            wait_for_fire: begin
                // redirect seen before acceptance, this fetch is already stale
                if (req_ready) begin
                    if (redirect_any) begin
                        state_d = ongoing_wasted_fetch;
                    end else if (from_redirect_q) begin
                        state_d = ongoing_redirect_fetch;
                    end else begin
                        state_d = ongoing_normal_fetch;
                    end
                end
            end
            ongoing_normal_fetch, ongoing_redirect_fetch: begin
                if (redirect_any) begin
                    state_d = rsp.done ? wasted_fetch_finish : ongoing_wasted_fetch;
                end else if (rsp.done) begin
                    state_d = (state_q == ongoing_normal_fetch) ? normal_finish
                                                                : redirect_finish;
                end
            end
            normal_finish, redirect_finish: begin
                // word dropped if a redirect lands now
                if (redirect_any) begin
                    load_target = 1'b1;
                    state_d     = wait_for_fire;
                end else begin
                    word_valid = 1'b1;
                    step_pc    = 1'b1;
                    state_d    = wait_for_ibuffer;
                end
            end
            wait_for_ibuffer: begin
                if (redirect_any) begin
                    load_target = 1'b1;
                    state_d     = wait_for_fire;
                end else if (can_accept) begin
                    state_d = wait_for_fire;
                end
            end
            ongoing_wasted_fetch: begin
                if (rsp.done) begin
                    state_d = wasted_fetch_finish;
                end
            end
            wasted_fetch_finish: begin
                load_target = 1'b1;
                state_d     = wait_for_fire;
            end
            default: begin
                state_d = boot_setting;
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state_q         <= boot_setting;
            pc              <= '0;
            from_redirect_q <= 1'b0;
            unaligned_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == boot_setting) begin
                pc <= boot_addr;
            end else if (load_target) begin
                pc              <= target_any;
                from_redirect_q <= 1'b1;
                // upper half only, next step is 4
                unaligned_q     <= target_any[2];
            end else if (step_pc) begin
                pc              <= pc + (unaligned_q ? addr_w'(4) : addr_w'(8));
                from_redirect_q <= 1'b0;
                unaligned_q     <= 1'b0;
            end
        end
    end

    // pending redirect until its target is loaded
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            redir_pend_q <= 1'b0;
        end else if (load_target) begin
            redir_pend_q <= 1'b0;
        end else if (redirect_valid) begin
            redir_pend_q <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (redirect_valid) begin
            redir_target_q <= redirect_target;
        end
        if (rsp.done) begin
            word_q <= rsp.data;
        end
    end

    // arbiter may stall, request must hold until granted
    req_held: assert property (@(posedge clock) disable iff (!reset_n)
        req.valid && !req_ready |=> req.valid && $stable(req.index));

endmodule

`default_nettype wire

/* src/ibuffer.sv */
`default_nettype none
`timescale 1ns/1ps

module ibuffer (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire                          word_valid,
    input  wire  [fetch_pkg::word_w-1:0] word_data,
    input  wire  [fetch_pkg::addr_w-1:0] word_pc,
    input  wire                          clear,
    output logic                         can_accept,
    output logic                         inst_valid,
    output logic [fetch_pkg::inst_w-1:0] inst_data,
    output logic [fetch_pkg::addr_w-1:0] inst_pc,
    input  wire                          inst_ready
);
    import fetch_pkg::*;

    logic              full_q;
    // 0 issues the low half, 1 the high half
    logic              upper_q;
    logic [word_w-1:0] word_q;
    logic [addr_w-4:0] base_q;
    logic              fire;

    assign fire       = full_q & inst_ready;
    assign inst_valid = full_q;
    assign inst_data  = upper_q ? word_q[word_w-1:inst_w] : word_q[inst_w-1:0];
    assign inst_pc    = {base_q, upper_q, 2'b00};

    // also open in the cycle the last half leaves
    assign can_accept = ~full_q | (fire & upper_q);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            full_q  <= 1'b0;
            upper_q <= 1'b0;
        end else if (clear) begin
            full_q <= 1'b0;
        end else if (word_valid) begin
            full_q  <= 1'b1;
            // unaligned word starts at its high half
            upper_q <= word_pc[2];
        end else if (fire) begin
            if (upper_q) begin
                full_q <= 1'b0;
            end else begin
                upper_q <= 1'b1;
            end
        end
    end

    // word and its aligned base
    always_ff @(posedge clock) begin
        if (word_valid) begin
            word_q <= word_data;
            base_q <= word_pc[addr_w-1:3];
        end
    end

    // pc_ctrl only fetches once the buffer has drained
    no_overwrite: assert property (@(posedge clock) disable iff (!reset_n)
        word_valid |-> !full_q);

endmodule

`default_nettype wire

/* src/channel_arb.sv */
`default_nettype none
`timescale 1ns/1ps

module channel_arb (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire  fetch_pkg::mem_req_t fetch_req,
    output logic                      fetch_ready,
    output fetch_pkg::mem_rsp_t       fetch_rsp,
    input  wire  fetch_pkg::mem_req_t data_req,
    output logic                      data_ready,
    output fetch_pkg::mem_rsp_t       data_rsp,
    output fetch_pkg::mem_req_t       mem_req,
    input  wire  fetch_pkg::mem_rsp_t mem_rsp
);
    import fetch_pkg::*;

    // one access in flight, from grant to done
    logic       busy_q;
    // owner of the current access, also the last winner
    arb_owner_e owner_q;
    arb_owner_e winner;
    logic       grant_fetch;
    logic       grant_data;
    logic       to_fetch;
    logic       to_data;

    always_comb begin
        // on a tie the last winner gives way
        grant_fetch = ~busy_q & fetch_req.valid &
                      (~data_req.valid | (owner_q == owner_data));
        grant_data  = ~busy_q & data_req.valid &
                      (~fetch_req.valid | (owner_q == owner_fetch));
        winner      = grant_data ? owner_data : owner_fetch;
    end

    assign fetch_ready = grant_fetch;
    assign data_ready  = grant_data;

    // request goes straight through in the grant cycle
    assign mem_req.valid = grant_fetch | grant_data;
    assign mem_req.index = grant_data ? data_req.index : fetch_req.index;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy_q  <= 1'b0;
            // fetch wins the first tie
            owner_q <= owner_data;
        end else if (mem_req.valid) begin
            busy_q  <= 1'b1;
            owner_q <= winner;
        end else if (mem_rsp.done) begin
            busy_q <= 1'b0;
        end
    end

    // response steered to the owner only
    assign to_fetch = busy_q & (owner_q == owner_fetch);
    assign to_data  = busy_q & (owner_q == owner_data);

    always_comb begin
        fetch_rsp.done = mem_rsp.done & to_fetch;
        fetch_rsp.data = to_fetch ? mem_rsp.data : '0;
        data_rsp.done  = mem_rsp.done & to_data;
        data_rsp.data  = to_data ? mem_rsp.data : '0;
    end

    // memory answers only what was granted
    done_when_busy: assert property (@(posedge clock) disable iff (!reset_n)
        mem_rsp.done |-> busy_q);

endmodule

`default_nettype wire

/* src/line_mem.sv */
`default_nettype none
`timescale 1ns/1ps

module line_mem (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire  fetch_pkg::mem_req_t req,
    output fetch_pkg::mem_rsp_t       rsp
);
    import fetch_pkg::*;

    logic [word_w-1:0]         mem [0:(1 << mem_index_bits)-1];
    logic [mem_latency-1:0]    valid_pipe;
    logic [mem_index_bits-1:0] index_pipe [0:mem_latency-1];

    // each instruction equals its own pc[12:2]
    function automatic logic [word_w-1:0] pattern_word(input logic [mem_index_bits-1:0] idx);
        logic [inst_w-1:0] lo;
        logic [inst_w-1:0] hi;
        lo = inst_w'({idx, 1'b0});
        hi = inst_w'({idx, 1'b1});
        return {hi, lo};
    endfunction

    // contents fixed once reset loads the pattern
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < (1 << mem_index_bits); i++) begin
                mem[i] <= pattern_word(mem_index_bits'(i));
            end
        end
    end

    // valid walks the pipe, done at the last stage
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= req.valid;
            for (int s = 1; s < mem_latency; s++) begin
                valid_pipe[s] <= valid_pipe[s-1];
            end
        end
    end

    // upper index bits dropped here
    always_ff @(posedge clock) begin
        index_pipe[0] <= req.index[mem_index_bits-1:0];
        for (int s = 1; s < mem_latency; s++) begin
            index_pipe[s] <= index_pipe[s-1];
        end
    end

    assign rsp.done = valid_pipe[mem_latency-1];
    assign rsp.data = mem[index_pipe[mem_latency-1]];

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`default_nettype none
`timescale 1ns/1ps

module fetch_top (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire  [fetch_pkg::addr_w-1:0] boot_addr,
    input  wire                          redirect_valid,
    input  wire  [fetch_pkg::addr_w-1:0] redirect_target,
    output logic                         inst_valid,
    output logic [fetch_pkg::inst_w-1:0] inst_data,
    output logic [fetch_pkg::addr_w-1:0] inst_pc,
    input  wire                          inst_ready,
    input  wire  fetch_pkg::mem_req_t    data_req,
    output logic                         data_ready,
    output fetch_pkg::mem_rsp_t          data_rsp
);
    import fetch_pkg::*;

    // fetch side of the arbiter
    mem_req_t          fetch_req;
    mem_rsp_t          fetch_rsp;
    logic              fetch_ready;
    // arbiter to memory
    mem_req_t          mem_req;
    mem_rsp_t          mem_rsp;
    // pc_ctrl to ibuffer
    logic [addr_w-1:0] pc;
    logic              word_valid;
    logic [word_w-1:0] word_data;
    logic              clear_ibuffer;
    logic              can_accept;

    pc_ctrl u_pc_ctrl (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .req             (fetch_req),
        .req_ready       (fetch_ready),
        .rsp             (fetch_rsp),
        .pc              (pc),
        .word_valid      (word_valid),
        .word_data       (word_data),
        .clear_ibuffer   (clear_ibuffer),
        .can_accept      (can_accept)
    );

    ibuffer u_ibuffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_pc    (pc),
        .clear      (clear_ibuffer),
        .can_accept (can_accept),
        .inst_valid (inst_valid),
        .inst_data  (inst_data),
        .inst_pc    (inst_pc),
        .inst_ready (inst_ready)
    );

    channel_arb u_channel_arb (
        .clock       (clock),
        .reset_n     (reset_n),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready),
        .fetch_rsp   (fetch_rsp),
        .data_req    (data_req),
        .data_ready  (data_ready),
        .data_rsp    (data_rsp),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

    line_mem u_line_mem (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (mem_req),
        .rsp     (mem_rsp)
    );

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module clock_gen (
    output logic clock,
    output logic reset_n
);
    // 100 ns period
    localparam int half_period  = 50;
    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #half_period clock = ~clock;
    end

    // released just after an edge, like every other input
    initial begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1 reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/tb_fetch.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_fetch;
    import fetch_pkg::*;

    localparam int n_steps = 8;
    // stream crosses 0x2000, where the memory index aliases
    localparam logic [addr_w-1:0] boot_pc = 48'h0000_0000_1ff0;

    // one row of the stimulus table
    typedef struct packed {
        logic [15:0]        n_insts;
        logic               do_redirect;
        logic [15:0]        redirect_after;
        logic [addr_w-1:0]  redirect_target;
        logic               do_read;
        logic [index_w-1:0] read_index;
        logic [7:0]         stall_pct;
    } step_t;

    logic              clock;
    logic              reset_n;
    logic [addr_w-1:0] boot_addr;
    logic              redirect_valid;
    logic [addr_w-1:0] redirect_target;
    logic              inst_valid;
    logic [inst_w-1:0] inst_data;
    logic [addr_w-1:0] inst_pc;
    logic              inst_ready;
    mem_req_t          data_req;
    logic              data_ready;
    mem_rsp_t          data_rsp;

    step_t              steps [n_steps];
    string              step_names [n_steps];
    string              current_test;
    // model state
    logic [addr_w-1:0]  exp_pc;
    logic [index_w-1:0] open_index;
    logic               redirected;
    logic               read_pending;
    int                 taken;
    int                 reads_open;
    int                 value_errors;
    int                 other_errors;
    int                 check_count;
    int                 cycle_count;
    int                 cycle_limit;
    integer             seed;

    clock_gen u_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    fetch_top dut (
        .clock           (clock),
        .reset_n         (reset_n),
        .boot_addr       (boot_addr),
        .redirect_valid  (redirect_valid),
        .redirect_target (redirect_target),
        .inst_valid      (inst_valid),
        .inst_data       (inst_data),
        .inst_pc         (inst_pc),
        .inst_ready      (inst_ready),
        .data_req        (data_req),
        .data_ready      (data_ready),
        .data_rsp        (data_rsp)
    );

    // instruction word is its own pc[12:2]
    function automatic logic [inst_w-1:0] inst_at(input logic [addr_w-1:0] pc_v);
        return inst_w'(pc_v[12:2]);
    endfunction

    // low half index*2, high half index*2+1, upper index bits alias
    function automatic logic [word_w-1:0] read_word(input logic [index_w-1:0] index);
        logic [inst_w-1:0] idx;
        idx = inst_w'(index[mem_index_bits-1:0]);
        return {idx * 32'd2 + 32'd1, idx * 32'd2};
    endfunction

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            value_errors++;
            $display("[ERROR] %s: %s expected 0x%0h, actual 0x%0h",
                     current_test, what, expected, actual);
        end
    endtask

    // drive 1 ns after the edge, sample at the falling edge
    task automatic run_cycle(input step_t cur);
        logic redirect_now;
        @(posedge clock);
        #1;
        redirect_now = cur.do_redirect && !redirected && (taken >= int'(cur.redirect_after));
        redirect_valid  = redirect_now;
        redirect_target = cur.redirect_target;
        data_req.valid  = read_pending;
        data_req.index  = cur.read_index;
        inst_ready      = ($unsigned($random(seed)) % 100) >= 32'(cur.stall_pct);
        @(negedge clock);
        // handshake completes at the coming edge
        if (inst_valid && inst_ready) begin
            check_value("inst_pc", 64'(exp_pc), 64'(inst_pc));
            check_value("inst_data", 64'(inst_at(exp_pc)), 64'(inst_data));
            exp_pc = exp_pc + addr_w'(4);
            taken++;
        end
        // old stream ends with this cycle, target comes next
        if (redirect_now) begin
            exp_pc     = cur.redirect_target;
            redirected = 1'b1;
        end
        if (data_req.valid && data_ready) begin
            read_pending = 1'b0;
            reads_open++;
            open_index = data_req.index;
        end
        if (data_rsp.done) begin
            if (reads_open == 0) begin
                other_errors++;
                $display("%s: data response arrived with no read outstanding", current_test);
            end else begin
                check_value("data_rsp.data", read_word(open_index), data_rsp.data);
                reads_open--;
            end
        end
    endtask

    // hang guard, limit set from the table at time zero
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout in %s: the run hung after %0d cycles", current_test, cycle_count);
            $display("checks %0d, value errors %0d, other errors %0d",
                     check_count, value_errors, other_errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        step_t cur;
        step_t idle;
        int    total;
        boot_addr       = boot_pc;
        redirect_valid  = 1'b0;
        redirect_target = '0;
        inst_ready      = 1'b0;
        data_req        = '0;
        seed            = 32'hac83_ad74;
        value_errors    = 0;
        other_errors    = 0;
        check_count     = 0;
        cycle_count     = 0;
        reads_open      = 0;
        read_pending    = 1'b0;
        redirected      = 1'b0;
        taken           = 0;
        exp_pc          = boot_pc;
        open_index      = '0;
        // n_insts, redirect?, after, target, read?, index, stall %
        steps[0] = '{16'd12, 1'b0, 16'd0, 48'h0000_0000_0000, 1'b0, 19'h0_0000, 8'd0};
        steps[1] = '{16'd10, 1'b1, 16'd3, 48'h0000_0040_0100, 1'b0, 19'h0_0000, 8'd0};
        steps[2] = '{16'd8, 1'b1, 16'd2, 48'h0000_0000_2344, 1'b0, 19'h0_0000, 8'd0};
        steps[3] = '{16'd8, 1'b0, 16'd0, 48'h0000_0000_0000, 1'b1, 19'h0_0025, 8'd0};
        steps[4] = '{16'd8, 1'b0, 16'd0, 48'h0000_0000_0000, 1'b1, 19'h4_03ff, 8'd0};
        steps[5] = '{16'd24, 1'b0, 16'd0, 48'h0000_0000_0000, 1'b0, 19'h0_0000, 8'd40};
        steps[6] = '{16'd12, 1'b1, 16'd4, 48'h0000_0000_0a0c, 1'b1, 19'h0_0200, 8'd60};
        steps[7] = '{16'd8, 1'b0, 16'd0, 48'h0000_0000_0000, 1'b0, 19'h0_0000, 8'd0};
        step_names[0] = "boot_stream";
        step_names[1] = "aligned_redirect";
        step_names[2] = "unaligned_redirect";
        step_names[3] = "data_read_low";
        step_names[4] = "data_read_alias";
        step_names[5] = "random_stalls";
        step_names[6] = "redirect_in_stall";
        step_names[7] = "tail_stream";
        total = 0;
        for (int s = 0; s < n_steps; s++) begin
            total += int'(steps[s].n_insts);
        end
        cycle_limit = total * 20 + 200;

        // outputs quiet through reset and the first cycle after it
        current_test = "reset_state";
        repeat (17) begin
            @(negedge clock);
            check_value("inst_valid", 64'd0, 64'(inst_valid));
            check_value("data_ready", 64'd0, 64'(data_ready));
            check_value("data_rsp.done", 64'd0, 64'(data_rsp.done));
        end

        // one stream runs across all rows
        for (int s = 0; s < n_steps; s++) begin
            cur          = steps[s];
            current_test = step_names[s];
            taken        = 0;
            redirected   = 1'b0;
            read_pending = cur.do_read;
            while (taken < int'(cur.n_insts) || read_pending || reads_open > 0) begin
                run_cycle(cur);
            end
        end

        // a stray second response would show up here
        idle           = '0;
        idle.stall_pct = 8'd100;
        current_test   = "drain";
        repeat (4) begin
            run_cycle(idle);
        end

        $display("checks %0d, value errors %0d, other errors %0d",
                 check_count, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/fetch_pkg.sv
src/pc_ctrl.sv
src/ibuffer.sv
src/channel_arb.sv
src/line_mem.sv
src/fetch_top.sv
tests/clock_gen.sv
tests/tb_fetch.sv

/* Makefile */
TOP := tb_fetch
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir $(LOG)
